// File: src.f
design/radio_core_pkg.sv
design/wb_slave_decode.sv
design/misc_regs.sv
design/settings_bus_16le.sv
design/readback_mux_16le.sv
design/vita_timer.sv
design/core_settings.sv
design/radio_core.sv
test/radio_core_tb.sv

// File: test/radio_core_tb.sv
// Radio core control plane testbench
`timescale 1ns/1ps

module radio_core_tb;

   import radio_core_pkg::*;

   localparam int CLK_PERIOD      = 40;
   localparam int ACK_TIMEOUT     = 16;                   // Cycles per bus access
   localparam int BUS_OPS         = 72;                   // Planned 16-bit accesses
   localparam int WATCHDOG_CYCLES = BUS_OPS * 20 + 500;

   logic wb_clk = 1'b0;
   logic wb_rst;
   logic [WB_AW-1:0] wb_adr_i;
   logic [WB_DW-1:0] wb_dat_i, wb_dat_o;
   logic wb_we_i, wb_cyc_i, wb_stb_i, wb_ack_o;
   logic cgen_st_status_i, cgen_st_ld_i, cgen_st_refmon_i;
   logic cgen_sync_b_o, cgen_ref_sel_o;
   logic pps_i;

   integer seed = 32'hf74d;
   int value_errors = 0;
   int timeout_errors = 0;
   int protocol_errors = 0;
   logic [31:0] rnd, rd32, test32_val;
   logic [15:0] rd16;
   logic [63:0] t_load, t_prev, t_now, t_pps;

   radio_core radio_core_i (.*);

   always #(CLK_PERIOD / 2) wb_clk = ~wb_clk;

   ////////////////////////////////////////////////////////////
   // Protocol checks
   ack_needs_strobe: assert property (@(posedge wb_clk) wb_ack_o |-> (wb_cyc_i && wb_stb_i))
   else
   begin
      protocol_errors++;
      $display("Acknowledge seen without cyc and stb at %0t ns", $time);
   end

   reset_cgen: assert property (@(posedge wb_clk)
                                wb_rst |-> ##2 (cgen_sync_b_o && cgen_ref_sel_o))
   else
   begin
      protocol_errors++;
      $display("Clock generator outputs not set by reset at %0t ns", $time);
   end

   task automatic check_value(input string sig, input logic [63:0] exp, input logic [63:0] got);
      assert (got === exp)
      else
      begin
         value_errors++;
         $display("FAILED at %0t ns: %s expected %h, got %h", $time, sig, exp, got);
      end
   endtask

   // One access, entered and left on a falling edge
   task automatic bus_cycle(input logic [WB_AW-1:0] adr, input logic we,
                            input logic [WB_DW-1:0] wdat, output logic [WB_DW-1:0] rdat);
      int waited;
      waited = 0;
      rdat = '0;
      wb_adr_i = adr;
      wb_dat_i = wdat;
      wb_we_i  = we;
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      #(CLK_PERIOD / 4);
      while (!wb_ack_o && waited < ACK_TIMEOUT)
      begin
         @(negedge wb_clk);
         #(CLK_PERIOD / 4);
         waited++;
      end
      if (wb_ack_o)
      begin
         rdat = wb_dat_o;
         @(posedge wb_clk);                  // Ack taken here
      end
      else
      begin
         timeout_errors++;
         $display("No acknowledge from address %h within %0d cycles at %0t ns",
                  adr, waited, $time);
      end
      @(negedge wb_clk);
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
      @(negedge wb_clk);                     // Idle cycle between accesses
   endtask

   task automatic wb_write(input logic [WB_AW-1:0] adr, input logic [WB_DW-1:0] dat);
      logic [WB_DW-1:0] unused;
      bus_cycle(adr, 1'b1, dat, unused);
   endtask

   task automatic wb_read(input logic [WB_AW-1:0] adr, output logic [WB_DW-1:0] dat);
      bus_cycle(adr, 1'b0, '0, dat);
   endtask

   task automatic write_setting(input logic [SET_AW-1:0] sr, input logic [SET_DW-1:0] val);
      wb_write({1'b1, sr, 1'b0, 1'b0}, val[15:0]);  // Low half first
      wb_write({1'b1, sr, 1'b1, 1'b0}, val[31:16]);
   endtask

   task automatic read_word(input logic [3:0] word, output logic [SET_DW-1:0] val);
      wb_read({4'h7, 1'b0, word, 1'b0, 1'b0}, val[15:0]);
      wb_read({4'h7, 1'b0, word, 1'b1, 1'b0}, val[31:16]);
   endtask

   // Words 0/1 give time, words 2/3 the PPS time
   task automatic read_time(input logic [3:0] word, output logic [63:0] val);
      read_word(word, val[63:32]);
      read_word(word + 4'd1, val[31:0]);
   endtask

   initial
   begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Watchdog expired after %0d cycles", WATCHDOG_CYCLES);
      $display("TESTS FAILED");
      $finish;
   end

   initial
   begin
      wb_rst = 1'b1;
      {wb_adr_i, wb_dat_i, wb_we_i, wb_cyc_i, wb_stb_i, pps_i} = '0;
      rnd = $random(seed);
      {cgen_st_status_i, cgen_st_ld_i, cgen_st_refmon_i} = rnd[2:0];
      repeat (3) @(negedge wb_clk);
      wb_rst = 1'b0;
      repeat (4) @(negedge wb_clk);          // Internal reset release

      ////////////////////////////////////////////////////////////
      // Reset values and misc registers
      check_value("cgen_sync_b_o", 1, cgen_sync_b_o);
      check_value("cgen_ref_sel_o", 1, cgen_ref_sel_o);
      wb_read({4'h0, REG_CGEN_CTRL}, rd16);
      check_value("REG_CGEN_CTRL", 16'd3, rd16);
      wb_read({4'h0, REG_TEST}, rd16);
      check_value("REG_TEST", 16'd0, rd16);
      wb_read({4'h0, 7'd16}, rd16);
      check_value("misc unmapped", 16'hBEEF, rd16);
      wb_read({4'h0, REG_CGEN_ST}, rd16);
      check_value("REG_CGEN_ST", {13'd0, rnd[2:0]}, rd16);
      for (int i = 0; i < 3; i++)
      begin
         rnd = $random(seed);
         wb_write({4'h0, REG_TEST}, rnd[15:0]);
         wb_read({4'h0, REG_TEST}, rd16);
         check_value("REG_TEST", rnd[15:0], rd16);
         wb_write({4'h0, REG_CGEN_CTRL}, rnd[31:16]);
         wb_read({4'h0, REG_CGEN_CTRL}, rd16);
         check_value("REG_CGEN_CTRL", rnd[31:16], rd16);
         check_value("cgen_sync_b_o", rnd[17], cgen_sync_b_o);
         check_value("cgen_ref_sel_o", rnd[16], cgen_ref_sel_o);
      end
      wb_write({4'h0, REG_CGEN_CTRL}, 16'd0);  // Both outputs low before global reset
      wb_write({4'h0, REG_TEST}, rnd[15:0] | 16'h1);
      check_value("cgen_sync_b_o", 0, cgen_sync_b_o);

      // Settings path and readback map
      test32_val = $random(seed);
      write_setting(SR_REG_TEST32, test32_val);
      read_word(4'd4, rd32);
      check_value("readback word 4", test32_val, rd32);
      read_word(4'd6, rd32);
      check_value("readback word 6", COMPAT_NUM, rd32);
      read_word(4'd9, rd32);
      check_value("readback word 9", 32'd0, rd32);

      ////////////////////////////////////////////////////////////
      // Timer load and count
      t_load = {$random(seed), $random(seed)};
      t_load[15:12] = 4'h0;                  // Keeps the low half from carrying
      write_setting(SR_TIME64, t_load[63:32]);
      write_setting(SR_TIME64 + 1, t_load[31:0]);
      t_prev = t_load;
      for (int i = 0; i < 4; i++)
      begin
         read_time(4'd0, t_now);
         assert (t_now >= t_load && t_now < t_load + WATCHDOG_CYCLES &&
                 (i == 0 || t_now > t_prev))
         else
         begin
            value_errors++;
            $display("FAILED at %0t ns: vita_time %h out of order after %h, loaded %h",
                     $time, t_now, t_prev, t_load);
         end
         t_prev = t_now;
      end

      // PPS capture
      read_time(4'd0, t_prev);
      pps_i = 1'b1;
      repeat (5) @(negedge wb_clk);
      pps_i = 1'b0;
      read_time(4'd2, t_pps);
      read_time(4'd0, t_now);
      assert (t_pps > t_prev && t_pps < t_now)
      else
      begin
         value_errors++;
         $display("FAILED at %0t ns: vita_time_pps %h not between %h and %h",
                  $time, t_pps, t_prev, t_now);
      end

      ////////////////////////////////////////////////////////////
      // Global reset through the settings bus
      read_time(4'd0, t_prev);
      write_setting(SR_GLOBAL_RESET, 32'd1);
      repeat (8) @(negedge wb_clk);
      wb_read({4'h0, REG_CGEN_CTRL}, rd16);
      check_value("REG_CGEN_CTRL", 16'd3, rd16);
      wb_read({4'h0, REG_TEST}, rd16);
      check_value("REG_TEST", 16'd0, rd16);
      read_time(4'd0, t_now);
      assert (t_now < t_prev)
      else
      begin
         value_errors++;
         $display("FAILED at %0t ns: vita_time %h did not restart below %h",
                  $time, t_now, t_prev);
      end
      read_word(4'd4, rd32);
      check_value("test32 after global reset", test32_val, rd32);

      $display("Errors: %0d value, %0d timeout, %0d protocol",
               value_errors, timeout_errors, protocol_errors);
      if (value_errors + timeout_errors + protocol_errors == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

endmodule

// File: design/radio_core.sv
// Radio core control plane
`timescale 1ns/1ps

module radio_core
  (input  logic                            wb_clk,
   input  logic                            wb_rst,
   input  logic [radio_core_pkg::WB_AW-1:0] wb_adr_i,
   input  logic [radio_core_pkg::WB_DW-1:0] wb_dat_i,
   input  logic                            wb_we_i,
   input  logic                            wb_cyc_i,
   input  logic                            wb_stb_i,
   output logic [radio_core_pkg::WB_DW-1:0] wb_dat_o,
   output logic                            wb_ack_o,
   input  logic                            cgen_st_status_i,
   input  logic                            cgen_st_ld_i,
   input  logic                            cgen_st_refmon_i,
   output logic                            cgen_sync_b_o,
   output logic                            cgen_ref_sel_o,
   input  logic                            pps_i);

   import radio_core_pkg::*;

   logic              core_rst;            // From the reset synchronizer
   logic [WB_AW-1:0]  s_adr;
   logic [WB_DW-1:0]  s_dat;
   logic              s_we;
   logic              misc_stb, misc_ack, rb_stb, rb_ack, set_bus_stb, set_bus_ack;
   logic [WB_DW-1:0]  misc_dat, rb_dat;
   logic              set_stb;
   logic [SET_AW-1:0] set_addr;
   logic [SET_DW-1:0] set_data;
   logic [SET_DW-1:0] test32;
   logic [2*SET_DW-1:0] vita_time, vita_time_pps;

   ////////////////////////////////////////////////////////////
   // Single master intercon
   wb_slave_decode wb_slave_decode_i
     (.m_adr_i(wb_adr_i), .m_dat_i(wb_dat_i), .m_we_i(wb_we_i),
      .m_cyc_i(wb_cyc_i), .m_stb_i(wb_stb_i),
      .m_dat_o(wb_dat_o), .m_ack_o(wb_ack_o),
      .misc_stb_o(misc_stb), .rb_stb_o(rb_stb), .set_bus_stb_o(set_bus_stb),
      .s_adr_o(s_adr), .s_dat_o(s_dat), .s_we_o(s_we),
      .misc_dat_i(misc_dat), .misc_ack_i(misc_ack),
      .rb_dat_i(rb_dat), .rb_ack_i(rb_ack), .set_bus_ack_i(set_bus_ack));

   // Slave 0
   misc_regs misc_regs_i
     (.wb_clk(wb_clk), .rst_i(core_rst), .stb_i(misc_stb), .we_i(s_we),
      .adr_i(s_adr), .dat_i(s_dat), .dat_o(misc_dat), .ack_o(misc_ack),
      .cgen_st_status_i(cgen_st_status_i), .cgen_st_ld_i(cgen_st_ld_i),
      .cgen_st_refmon_i(cgen_st_refmon_i),
      .cgen_sync_b_o(cgen_sync_b_o), .cgen_ref_sel_o(cgen_ref_sel_o));

   // Slave 8, eight slots wide
   settings_bus_16le settings_bus_16le_i
     (.wb_clk(wb_clk), .rst_i(core_rst), .stb_i(set_bus_stb), .we_i(s_we),
      .adr_i(s_adr), .dat_i(s_dat), .ack_o(set_bus_ack),
      .set_stb_o(set_stb), .set_addr_o(set_addr), .set_data_o(set_data));

   // Slave 7
   readback_mux_16le #(.COMPAT(COMPAT_NUM)) readback_mux_16le_i
     (.wb_clk(wb_clk), .rst_i(core_rst), .stb_i(rb_stb), .adr_i(s_adr),
      .dat_o(rb_dat), .ack_o(rb_ack),
      .vita_time_i(vita_time), .vita_time_pps_i(vita_time_pps), .test32_i(test32));

   ////////////////////////////////////////////////////////////
   // Setting consumers
   vita_timer #(.BASE(SR_TIME64)) vita_timer_i
     (.wb_clk(wb_clk), .rst_i(core_rst), .set_stb_i(set_stb),
      .set_addr_i(set_addr), .set_data_i(set_data), .pps_i(pps_i),
      .vita_time_o(vita_time), .vita_time_pps_o(vita_time_pps));

   core_settings #(.TEST32_ADDR(SR_REG_TEST32), .RESET_ADDR(SR_GLOBAL_RESET))
   core_settings_i
     (.wb_clk(wb_clk), .wb_rst(wb_rst), .set_stb_i(set_stb),
      .set_addr_i(set_addr), .set_data_i(set_data),
      .test32_o(test32), .rst_o(core_rst));

endmodule

// File: design/core_settings.sv
// Core settings and reset generation
`timescale 1ns/1ps

module core_settings
  #(parameter int TEST32_ADDR = radio_core_pkg::SR_REG_TEST32,
    parameter int RESET_ADDR  = radio_core_pkg::SR_GLOBAL_RESET)
  (input  logic                             wb_clk,
   input  logic                             wb_rst,
   input  logic                             set_stb_i,
   input  logic [radio_core_pkg::SET_AW-1:0] set_addr_i,
   input  logic [radio_core_pkg::SET_DW-1:0] set_data_i,
   output logic [radio_core_pkg::SET_DW-1:0] test32_o,
   output logic                             rst_o);

   import radio_core_pkg::*;

   logic       rst_pulse;                  // Global reset request
   logic       rst_req;
   logic [1:0] rst_sync;

   // Survives global reset so software can tell the FPGA stayed loaded
   always_ff @(posedge wb_clk)
   begin
      if (set_stb_i && (set_addr_i == SET_AW'(TEST32_ADDR)))
         test32_o <= set_data_i;
   end

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         rst_pulse <= 1'b0;
      else
         rst_pulse <= set_stb_i && (set_addr_i == SET_AW'(RESET_ADDR));
   end

   assign rst_req = wb_rst | rst_pulse;

   // Both stages set together, release ripples out over two edges
   always_ff @(posedge wb_clk)
   begin
      if (rst_req)
         rst_sync <= 2'b11;
      else
         rst_sync <= {rst_sync[0], 1'b0};
   end

   assign rst_o = rst_sync[1];

endmodule

// File: design/vita_timer.sv
// 64-bit VITA tick counter
`timescale 1ns/1ps

module vita_timer
  #(parameter int BASE = radio_core_pkg::SR_TIME64)
  (input  logic                               wb_clk,
   input  logic                               rst_i,
   input  logic                               set_stb_i,
   input  logic [radio_core_pkg::SET_AW-1:0]   set_addr_i,
   input  logic [radio_core_pkg::SET_DW-1:0]   set_data_i,
   input  logic                               pps_i,
   output logic [2*radio_core_pkg::SET_DW-1:0] vita_time_o,
   output logic [2*radio_core_pkg::SET_DW-1:0] vita_time_pps_o);

   import radio_core_pkg::*;

   localparam logic [SET_AW-1:0] ADDR_HI = SET_AW'(BASE);
   localparam logic [SET_AW-1:0] ADDR_LO = SET_AW'(BASE + 1);

   logic [SET_DW-1:0] time_hi_pend;        // Held until the low word loads
   logic              load;
   logic              pps_meta, pps_sync, pps_prev;
   logic              pps_rise;

   assign load = set_stb_i && (set_addr_i == ADDR_LO);

   always_ff @(posedge wb_clk)
   begin
      if (set_stb_i && (set_addr_i == ADDR_HI))
         time_hi_pend <= set_data_i;
   end

   ////////////////////////////////////////////////////////////
   // Tick counter
   always_ff @(posedge wb_clk)
   begin
      if (rst_i)
         vita_time_o <= '0;
      else if (load)
         vita_time_o <= {time_hi_pend, set_data_i};
      else
         vita_time_o <= vita_time_o + 1'b1;
   end

   ////////////////////////////////////////////////////////////
   // PPS capture
   // pps_i is asynchronous to wb_clk
   always_ff @(posedge wb_clk)
   begin
      if (rst_i)
      begin
         pps_meta <= 1'b0;
         pps_sync <= 1'b0;
         pps_prev <= 1'b0;
      end
      else
      begin
         pps_meta <= pps_i;
         pps_sync <= pps_meta;
         pps_prev <= pps_sync;
      end
   end

   assign pps_rise = pps_sync & ~pps_prev;

   always_ff @(posedge wb_clk)
   begin
      if (rst_i)
         vita_time_pps_o <= '0;
      else if (pps_rise)
         vita_time_pps_o <= vita_time_o;   // Third edge after the input rises
   end

endmodule

// File: design/readback_mux_16le.sv
// 32-bit status readback in 16-bit halves
`timescale 1ns/1ps

module readback_mux_16le
  #(parameter logic [radio_core_pkg::SET_DW-1:0] COMPAT = radio_core_pkg::COMPAT_NUM)
  (input  logic                               wb_clk,
   input  logic                               rst_i,
   input  logic                               stb_i,
   input  logic [radio_core_pkg::WB_AW-1:0]    adr_i,
   output logic [radio_core_pkg::WB_DW-1:0]    dat_o,
   output logic                               ack_o,
   input  logic [2*radio_core_pkg::SET_DW-1:0] vita_time_i,
   input  logic [2*radio_core_pkg::SET_DW-1:0] vita_time_pps_i,
   input  logic [radio_core_pkg::SET_DW-1:0]   test32_i);

   import radio_core_pkg::*;

   logic [SET_DW-1:0] rb_word [RB_WORDS];
   logic [SET_DW-1:0] sel_word;

   // Word map
   always_comb
   begin
      for (int i = 0; i < RB_WORDS; i++)
         rb_word[i] = '0;
      rb_word[0] = vita_time_i[2*SET_DW-1:SET_DW];
      rb_word[1] = vita_time_i[SET_DW-1:0];
      rb_word[2] = vita_time_pps_i[2*SET_DW-1:SET_DW];
      rb_word[3] = vita_time_pps_i[SET_DW-1:0];
      rb_word[4] = test32_i;
      rb_word[6] = COMPAT;
   end

   assign sel_word = rb_word[adr_i[5:2]];

   // Data lands with ack
   always_ff @(posedge wb_clk)
   begin
      dat_o <= adr_i[1] ? sel_word[SET_DW-1:WB_DW] : sel_word[WB_DW-1:0];
   end

   always_ff @(posedge wb_clk)
   begin
      if (rst_i)
         ack_o <= 1'b0;
      else
         ack_o <= stb_i & ~ack_o;          // One-cycle gap between acks
   end

   // Returned half was registered from the address still on the bus
   ack_adr_held: assert property (@(posedge wb_clk) disable iff (rst_i)
                                  ack_o |-> $stable(adr_i[5:1]));

endmodule

// File: design/settings_bus_16le.sv
// 16-bit to 32-bit settings bus
`timescale 1ns/1ps

module settings_bus_16le
  (input  logic                             wb_clk,
   input  logic                             rst_i,
   input  logic                             stb_i,
   input  logic                             we_i,
   input  logic [radio_core_pkg::WB_AW-1:0]  adr_i,
   input  logic [radio_core_pkg::WB_DW-1:0]  dat_i,
   output logic                             ack_o,
   output logic                             set_stb_o,
   output logic [radio_core_pkg::SET_AW-1:0] set_addr_o,
   output logic [radio_core_pkg::SET_DW-1:0] set_data_o);

   import radio_core_pkg::*;

   logic [WB_DW-1:0] low_half;             // Waits for the high half
   logic             wr_lo, wr_hi;

   assign wr_lo = stb_i & we_i & ~adr_i[1];
   assign wr_hi = stb_i & we_i &  adr_i[1];

   always_ff @(posedge wb_clk)
   begin
      if (wr_lo)
         low_half <= dat_i;
      if (wr_hi)
      begin
         set_addr_o <= adr_i[SET_AW+1:2];
         set_data_o <= {dat_i, low_half};
      end
   end

   // High half commits the setting
   always_ff @(posedge wb_clk)
   begin
      if (rst_i)
         set_stb_o <= 1'b0;
      else
         set_stb_o <= wr_hi;
   end

   assign ack_o = stb_i;

   // Master drops stb after each ack, so a setting is a single pulse
   set_stb_single: assert property (@(posedge wb_clk) disable iff (rst_i)
                                    set_stb_o |=> !set_stb_o);

endmodule

// File: design/misc_regs.sv
// Clock generator and test registers
`timescale 1ns/1ps

module misc_regs
  (input  logic                            wb_clk,
   input  logic                            rst_i,
   input  logic                            stb_i,
   input  logic                            we_i,
   input  logic [radio_core_pkg::WB_AW-1:0] adr_i,
   input  logic [radio_core_pkg::WB_DW-1:0] dat_i,
   output logic [radio_core_pkg::WB_DW-1:0] dat_o,
   output logic                            ack_o,
   input  logic                            cgen_st_status_i,
   input  logic                            cgen_st_ld_i,
   input  logic                            cgen_st_refmon_i,
   output logic                            cgen_sync_b_o,
   output logic                            cgen_ref_sel_o);

   import radio_core_pkg::*;

   logic [WB_DW-1:0] reg_cgen_ctrl;
   logic [WB_DW-1:0] reg_test;

   always_ff @(posedge wb_clk)
   begin
      if (rst_i)
      begin
         reg_cgen_ctrl <= 16'd3;           // Sync deasserted, external ref
         reg_test      <= '0;
      end
      else if (stb_i && we_i)
      begin
         case (adr_i[6:0])
            REG_CGEN_CTRL: reg_cgen_ctrl <= dat_i;
            REG_TEST:      reg_test      <= dat_i;
            default:       ;
         endcase
      end
   end

   assign {cgen_sync_b_o, cgen_ref_sel_o} = reg_cgen_ctrl[1:0];

   always_comb
   begin
      case (adr_i[6:0])
         REG_CGEN_CTRL: dat_o = reg_cgen_ctrl;
         REG_CGEN_ST:   dat_o = {13'd0, cgen_st_status_i, cgen_st_ld_i, cgen_st_refmon_i};
         REG_TEST:      dat_o = reg_test;
         default:       dat_o = MISC_DEFAULT_READ;
      endcase
   end

   assign ack_o = stb_i;                   // Zero wait state

endmodule

// File: design/wb_slave_decode.sv
// Single master address decoder
`timescale 1ns/1ps

module wb_slave_decode
  (input  logic [radio_core_pkg::WB_AW-1:0] m_adr_i,
   input  logic [radio_core_pkg::WB_DW-1:0] m_dat_i,
   input  logic                            m_we_i,
   input  logic                            m_cyc_i,
   input  logic                            m_stb_i,
   output logic [radio_core_pkg::WB_DW-1:0] m_dat_o,
   output logic                            m_ack_o,
   output logic                            misc_stb_o,
   output logic                            rb_stb_o,
   output logic                            set_bus_stb_o,
   output logic [radio_core_pkg::WB_AW-1:0] s_adr_o,
   output logic [radio_core_pkg::WB_DW-1:0] s_dat_o,
   output logic                            s_we_o,
   input  logic [radio_core_pkg::WB_DW-1:0] misc_dat_i,
   input  logic                            misc_ack_i,
   input  logic [radio_core_pkg::WB_DW-1:0] rb_dat_i,
   input  logic                            rb_ack_i,
   input  logic                            set_bus_ack_i);

   import radio_core_pkg::*;

   wb_slave_e slv;
   logic      access;                      // Live bus cycle

   // Top four address bits pick the slave
   always_comb
   begin
      if (m_adr_i[WB_AW-1])
         slv = SLV_SETTINGS;               // Upper half of the map
      else if (m_adr_i[WB_AW-1:WB_AW-4] == 4'h0)
         slv = SLV_MISC;
      else if (m_adr_i[WB_AW-1:WB_AW-4] == 4'h7)
         slv = SLV_READBACK;
      else
         slv = SLV_NONE;
   end

   assign access        = m_cyc_i & m_stb_i;
   assign misc_stb_o    = access & (slv == SLV_MISC);
   assign rb_stb_o      = access & (slv == SLV_READBACK);
   assign set_bus_stb_o = access & (slv == SLV_SETTINGS);

   assign s_adr_o = m_adr_i;
   assign s_dat_o = m_dat_i;
   assign s_we_o  = m_we_i;

   // Return path, unmapped space stays silent
   always_comb
   begin
      case (slv)
         SLV_MISC:     {m_dat_o, m_ack_o} = {misc_dat_i, misc_ack_i};
         SLV_READBACK: {m_dat_o, m_ack_o} = {rb_dat_i, rb_ack_i};
         SLV_SETTINGS: {m_dat_o, m_ack_o} = {{WB_DW{1'b0}}, set_bus_ack_i};
         default:      {m_dat_o, m_ack_o} = {{WB_DW{1'b0}}, 1'b0};
      endcase
   end

   // Registered slave acks must still fall before the master drops its strobe
   always_comb
   begin
      if (m_ack_o)
         ack_in_cycle: assert final (m_cyc_i && m_stb_i);
   end

endmodule

// File: design/radio_core_pkg.sv
// Radio core control-plane definitions
package radio_core_pkg;

   ////////////////////////////////////////////////////////////
   // Bus and settings geometry
   localparam int WB_DW  = 16;        // Master data width
   localparam int WB_AW  = 11;        // Master byte address width
   localparam int SET_AW = 8;         // Setting register address
   localparam int SET_DW = 32;        // Setting register data

   // Slave picked by address bits 10:7
   typedef enum logic [1:0] {
      SLV_MISC,                       // 4'h0
      SLV_READBACK,                   // 4'h7
      SLV_SETTINGS,                   // 4'h8 to 4'hF
      SLV_NONE
   } wb_slave_e;

   ////////////////////////////////////////////////////////////
   // Setting register map
   localparam int SR_TIME64       = 42;   // +0 time high, +1 time low and load
   localparam int SR_REG_TEST32   = 60;
   localparam int SR_GLOBAL_RESET = 63;

   // Misc slave offsets on address bits 6:0
   localparam logic [6:0] REG_CGEN_CTRL = 7'd4;
   localparam logic [6:0] REG_CGEN_ST   = 7'd6;
   localparam logic [6:0] REG_TEST      = 7'd8;

   localparam logic [WB_DW-1:0] MISC_DEFAULT_READ = 16'hBEEF;

   ////////////////////////////////////////////////////////////
   // Readback
   // Bump when the register map changes in an incompatible way
   localparam logic [SET_DW-1:0] COMPAT_NUM = {16'd8, 16'd1};   // Major, minor
   localparam int RB_WORDS = 16;

endpackage
